// ==== design/debayer_pkg.sv ====
package debayer_pkg;

	localparam int PIXEL_WIDTH = 10;	// raw10 sample
	localparam int LINE_PIXELS = 16;	// fixed image width
	localparam int COL_WIDTH   = 4;	// enough for LINE_PIXELS-1
	localparam int SUM_WIDTH   = 12;	// four samples without overflow

	typedef logic [PIXEL_WIDTH-1:0] pixel_t;
	typedef logic [COL_WIDTH-1:0]   col_idx_t;

	typedef struct packed
	{
		pixel_t red;
		pixel_t green;
		pixel_t blue;
	} rgb_t;

	// one column of the 3x3 neighbourhood
	typedef struct packed
	{
		pixel_t top;
		pixel_t mid;
		pixel_t bot;
	} column_t;

	typedef struct packed
	{
		column_t left;
		column_t centre;
		column_t right;
	} window_t;

	// encoding is {row odd, column odd} for RGGB
	typedef enum logic [1:0]
	{
		SITE_R  = 2'b00,
		SITE_GR = 2'b01,
		SITE_GB = 2'b10,
		SITE_B  = 2'b11
	} bayer_site_e;

endpackage

// ==== design/line_buffer_ram.sv ====
`timescale 1ns/1ps

module line_buffer_ram
	import debayer_pkg::*;
(
	input  logic     clk_i,
	input  logic     line_valid_i,
	input  logic     wr_en_i,
	input  col_idx_t addr_i,
	input  pixel_t   wr_data_i,
	output pixel_t   rd_data_o
);

	pixel_t mem [LINE_PIXELS];	// one full line

	// read is combinational, so the old sample is seen before the write edge
	assign rd_data_o = mem[addr_i];

	always_ff @(posedge clk_i)
	begin
		if (wr_en_i && !line_valid_i)	// no writes while held in reset
		begin
			mem[addr_i] <= wr_data_i;
		end
	end

endmodule

// ==== design/line_store.sv ====
`timescale 1ns/1ps

module line_store
	import debayer_pkg::*;
(
	input  logic        clk_i,
	input  logic        line_valid_i,
	input  pixel_t      pix_i,
	input  logic        pix_valid_i,
	output logic        pix_ready_o,
	output column_t     col_o,
	output bayer_site_e col_site_o,
	output logic        col_last_o,
	output logic        col_valid_o,
	input  logic        col_ready_i
);

	col_idx_t   col_cnt;
	logic [1:0] row_cnt;	// saturates at 2
	logic       row_par;	// parity of the incoming row
	logic       sel;	// RAM holding the older line
	logic       accept;
	logic       last_col;
	pixel_t     rd_data [2];
	pixel_t     older;
	pixel_t     newer;

	assign pix_ready_o = !col_valid_o || col_ready_i;
	assign accept      = pix_valid_i && pix_ready_o;
	assign last_col    = (col_cnt == col_idx_t'(LINE_PIXELS - 1));
	assign older       = sel ? rd_data[1] : rd_data[0];
	assign newer       = sel ? rd_data[0] : rd_data[1];

	line_buffer_ram i_ram0 (
		.clk_i       (clk_i),
		.line_valid_i(line_valid_i),
		.wr_en_i     (accept && !sel),	// new pixel replaces the older line
		.addr_i      (col_cnt),
		.wr_data_i   (pix_i),
		.rd_data_o   (rd_data[0])
	);

	line_buffer_ram i_ram1 (
		.clk_i       (clk_i),
		.line_valid_i(line_valid_i),
		.wr_en_i     (accept && sel),
		.addr_i      (col_cnt),
		.wr_data_i   (pix_i),
		.rd_data_o   (rd_data[1])
	);

	always_ff @(posedge clk_i or posedge line_valid_i)
	begin
		if (line_valid_i)
		begin
			col_cnt     <= '0;
			row_cnt     <= '0;
			row_par     <= 1'b0;
			sel         <= 1'b0;
			col_valid_o <= 1'b0;
		end
		else
		begin
			if (col_valid_o && col_ready_i)
			begin
				col_valid_o <= 1'b0;
			end
			if (accept)
			begin
				col_valid_o <= (row_cnt != 2'd0);	// row 0 is only stored
				col_cnt     <= last_col ? '0 : col_cnt + 1'b1;
				if (last_col)
				begin
					sel     <= !sel;	// just-written line becomes the newest
					row_par <= !row_par;
					if (row_cnt != 2'd2)
					begin
						row_cnt <= row_cnt + 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (accept)
		begin
			col_o.top  <= (row_cnt == 2'd1) ? pix_i : older;	// row -1 mirrors row 1
			col_o.mid  <= newer;
			col_o.bot  <= pix_i;
			col_site_o <= bayer_site_e'({!row_par, col_cnt[0]});	// middle row parity
			col_last_o <= last_col;
		end
	end

endmodule

// ==== design/window_3x3.sv ====
`timescale 1ns/1ps

module window_3x3
	import debayer_pkg::*;
(
	input  logic        clk_i,
	input  logic        line_valid_i,
	input  column_t     col_i,
	input  bayer_site_e col_site_i,
	input  logic        col_last_i,
	input  logic        col_valid_i,
	output logic        col_ready_o,
	output window_t     win_o,
	output bayer_site_e win_site_o,
	output logic        win_valid_o,
	input  logic        win_ready_i
);

	typedef enum logic [1:0]
	{
		IDLE,
		FILL,
		STREAM,
		FLUSH
	} win_state_e;

	win_state_e  state_q;
	column_t     left_q;
	column_t     centre_q;
	column_t     right_q;
	bayer_site_e last_site_q;	// site of the newest column
	logic        slot_free;
	logic        col_accept;
	logic        flush_go;
	logic        emit;

	assign slot_free   = !win_valid_o || win_ready_i;
	assign col_ready_o = (state_q != FLUSH) && slot_free;	// low for the flush beat
	assign col_accept  = col_valid_i && col_ready_o;
	assign flush_go    = (state_q == FLUSH) && slot_free;
	assign emit        = (col_accept && state_q != IDLE) || flush_go;

	assign win_o = {left_q, centre_q, right_q};

	always_ff @(posedge clk_i or posedge line_valid_i)
	begin
		if (line_valid_i)
		begin
			state_q     <= IDLE;
			win_valid_o <= 1'b0;
		end
		else
		begin
			if (emit)
				win_valid_o <= 1'b1;
			else if (win_ready_i)
				win_valid_o <= 1'b0;

			case (state_q)
				IDLE:
					if (col_accept)
						state_q <= FILL;	// column 0 held
				FILL, STREAM:
					if (col_accept)
						state_q <= col_last_i ? FLUSH : STREAM;
				FLUSH:
					if (slot_free)
						state_q <= IDLE;
				default:
					state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (col_accept)
		begin
			right_q     <= col_i;
			centre_q    <= right_q;
			left_q      <= (state_q == FILL) ? col_i : centre_q;	// column -1 mirrors 1
			last_site_q <= col_site_i;
		end
		else if (flush_go)
		begin
			left_q   <= centre_q;
			centre_q <= right_q;
			right_q  <= centre_q;	// column W mirrors W-2
		end
		if (emit)
			win_site_o <= last_site_q;
	end

endmodule

// ==== design/bayer_interp.sv ====
`timescale 1ns/1ps

module bayer_interp
	import debayer_pkg::*;
(
	input  logic        clk_i,
	input  logic        line_valid_i,
	input  window_t     win_i,
	input  bayer_site_e win_site_i,
	input  logic        win_valid_i,
	output logic        win_ready_o,
	output rgb_t        rgb_o,
	output logic        rgb_valid_o,
	input  logic        rgb_ready_i
);

	pixel_t native;	// centre sample
	pixel_t orth;	// up, down, left, right
	pixel_t diag;	// four corners
	pixel_t horiz;	// left, left, right, right
	pixel_t vert;	// up, up, down, down
	rgb_t   rgb_next;
	logic   win_accept;

	// sum of four terms, divided by four
	function automatic pixel_t avg4(input pixel_t a, input pixel_t b,
		input pixel_t c, input pixel_t d);
		logic [SUM_WIDTH-1:0] sum;
		sum = SUM_WIDTH'(a) + SUM_WIDTH'(b) + SUM_WIDTH'(c) + SUM_WIDTH'(d);
		return sum[SUM_WIDTH-1:2];
	endfunction

	assign native = avg4(win_i.centre.mid, win_i.centre.mid, win_i.centre.mid,
		win_i.centre.mid);
	assign orth   = avg4(win_i.centre.top, win_i.centre.bot, win_i.left.mid,
		win_i.right.mid);
	assign diag   = avg4(win_i.left.top, win_i.right.top, win_i.left.bot,
		win_i.right.bot);
	assign horiz  = avg4(win_i.left.mid, win_i.left.mid, win_i.right.mid,
		win_i.right.mid);
	assign vert   = avg4(win_i.centre.top, win_i.centre.top, win_i.centre.bot,
		win_i.centre.bot);

	always_comb
	begin
		case (win_site_i)
			SITE_R:  rgb_next = '{red: native, green: orth, blue: diag};
			SITE_GR: rgb_next = '{red: horiz, green: native, blue: vert};	// red row
			SITE_GB: rgb_next = '{red: vert, green: native, blue: horiz};	// blue row
			default: rgb_next = '{red: diag, green: orth, blue: native};
		endcase
	end

	assign win_ready_o = !rgb_valid_o || rgb_ready_i;
	assign win_accept  = win_valid_i && win_ready_o;

	always_ff @(posedge clk_i or posedge line_valid_i)
	begin
		if (line_valid_i)
		begin
			rgb_valid_o <= 1'b0;
		end
		else if (win_accept)
		begin
			rgb_valid_o <= 1'b1;
		end
		else if (rgb_ready_i)
		begin
			rgb_valid_o <= 1'b0;	// drained
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (win_accept)
			rgb_o <= rgb_next;
	end

endmodule

// ==== design/debayer_top.sv ====
`timescale 1ns/1ps

module debayer_top
	import debayer_pkg::*;
(
	input  logic   clk_i,
	input  logic   line_valid_i,
	input  pixel_t pix_i,
	input  logic   pix_valid_i,
	output logic   pix_ready_o,
	output rgb_t   rgb_o,
	output logic   rgb_valid_o,
	input  logic   rgb_ready_i
);

	column_t     col;
	bayer_site_e col_site;
	logic        col_last;
	logic        col_valid;
	logic        col_ready;
	window_t     win;
	bayer_site_e win_site;
	logic        win_valid;
	logic        win_ready;

	line_store i_line_store (
		.clk_i       (clk_i),
		.line_valid_i(line_valid_i),
		.pix_i       (pix_i),
		.pix_valid_i (pix_valid_i),
		.pix_ready_o (pix_ready_o),
		.col_o       (col),
		.col_site_o  (col_site),
		.col_last_o  (col_last),
		.col_valid_o (col_valid),
		.col_ready_i (col_ready)
	);

	window_3x3 i_window (
		.clk_i       (clk_i),
		.line_valid_i(line_valid_i),
		.col_i       (col),
		.col_site_i  (col_site),
		.col_last_i  (col_last),
		.col_valid_i (col_valid),
		.col_ready_o (col_ready),
		.win_o       (win),
		.win_site_o  (win_site),
		.win_valid_o (win_valid),
		.win_ready_i (win_ready)
	);

	bayer_interp i_interp (
		.clk_i       (clk_i),
		.line_valid_i(line_valid_i),
		.win_i       (win),
		.win_site_i  (win_site),
		.win_valid_i (win_valid),
		.win_ready_o (win_ready),
		.rgb_o       (rgb_o),
		.rgb_valid_o (rgb_valid_o),
		.rgb_ready_i (rgb_ready_i)
	);

endmodule

// ==== tb/debayer_checker.sv ====
`timescale 1ns/1ps

module debayer_checker
	import debayer_pkg::*;
(
	input logic   clk_i,
	input logic   line_valid_i,
	input pixel_t pix_i,
	input logic   pix_valid_i,
	input logic   pix_ready_o,
	input rgb_t   rgb_o,
	input logic   rgb_valid_o,
	input logic   rgb_ready_i
);

	int assert_fails = 0;	// failed assertions so far

	in_hold: assert property (@(posedge clk_i) disable iff (line_valid_i)
		pix_valid_i && !pix_ready_o |=> pix_valid_i && $stable(pix_i))
	else
	begin
		$error("input beat changed while stalled");
		assert_fails++;
	end

	out_hold: assert property (@(posedge clk_i) disable iff (line_valid_i)
		rgb_valid_o && !rgb_ready_i |=> rgb_valid_o && $stable(rgb_o))
	else
	begin
		$error("output beat changed while stalled");
		assert_fails++;
	end

	// the pulse empties the output stage
	reset_drop: assert property (@(posedge clk_i) line_valid_i |=> !rgb_valid_o)
	else
	begin
		$error("rgb_valid_o high after line_valid_i");
		assert_fails++;
	end

	ready_known: assert property (@(posedge clk_i) !line_valid_i |-> !$isunknown(pix_ready_o))
	else
	begin
		$error("pix_ready_o unknown out of reset");
		assert_fails++;
	end

endmodule

bind debayer_top debayer_checker i_checker (
	.clk_i       (clk_i),
	.line_valid_i(line_valid_i),
	.pix_i       (pix_i),
	.pix_valid_i (pix_valid_i),
	.pix_ready_o (pix_ready_o),
	.rgb_o       (rgb_o),
	.rgb_valid_o (rgb_valid_o),
	.rgb_ready_i (rgb_ready_i)
);

// ==== tb/debayer_tb.sv ====
`timescale 1ns/1ps

module debayer_tb
	import debayer_pkg::*;
();

	localparam int MAX_ROWS  = 12;
	localparam int NUM_TESTS = 8;
	localparam int TIMEOUT   = 5000;	// cycles per frame

	typedef enum logic [1:0] {PAT_CONST, PAT_HRAMP, PAT_VRAMP, PAT_RANDOM} pattern_e;

	typedef struct packed
	{
		logic [8*12-1:0] name;
		pattern_e        pattern;
		logic [3:0]      height;
		logic            stall;	// random rgb_ready_i
		logic [7:0]      abort_at;	// pixels before a mid-frame pulse, 0 for a whole frame
	} test_entry_t;

	localparam test_entry_t TESTS [NUM_TESTS] = '{
		'{"flat_field  ", PAT_CONST,  4'd4, 1'b0, 8'd0},
		'{"h_ramp      ", PAT_HRAMP,  4'd4, 1'b0, 8'd0},
		'{"v_ramp      ", PAT_VRAMP,  4'd6, 1'b0, 8'd0},
		'{"random_edges", PAT_RANDOM, 4'd8, 1'b0, 8'd0},
		'{"stall_random", PAT_RANDOM, 4'd8, 1'b1, 8'd0},
		'{"reset_mid   ", PAT_RANDOM, 4'd6, 1'b1, 8'd40},
		'{"after_reset ", PAT_VRAMP,  4'd3, 1'b1, 8'd0},
		'{"two_rows    ", PAT_RANDOM, 4'd2, 1'b0, 8'd0}
	};

	logic        clk_i;
	logic        line_valid_i;
	pixel_t      pix_i;
	logic        pix_valid_i;
	logic        pix_ready_o;
	rgb_t        rgb_o;
	logic        rgb_valid_o;
	logic        rgb_ready_i;
	pixel_t      frame [MAX_ROWS][LINE_PIXELS];
	rgb_t        expected_q [$];
	logic [31:0] rng_state;
	string       test_name;
	int          n;

	debayer_top i_dut (
		.clk_i       (clk_i),
		.line_valid_i(line_valid_i),
		.pix_i       (pix_i),
		.pix_valid_i (pix_valid_i),
		.pix_ready_o (pix_ready_o),
		.rgb_o       (rgb_o),
		.rgb_valid_o (rgb_valid_o),
		.rgb_ready_i (rgb_ready_i)
	);

	always #2 clk_i = ~clk_i;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// border reads reflect about the edge sample, keeping the colour phase
	function automatic int sample(input int r, input int c);
		int rr;
		int cc;
		rr = (r < 0) ? -r : r;
		cc = (c < 0) ? -c : c;
		if (cc >= LINE_PIXELS)
			cc = 2 * (LINE_PIXELS - 1) - cc;
		return int'(frame[rr][cc]);
	endfunction

	function automatic pixel_t mean4(input int a, input int b, input int c, input int d);
		return pixel_t'((a + b + c + d) / 4);
	endfunction

	task automatic abort_run();
		$display("=== FAIL ===");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("FAILED %s %s expected %h actual %h", test_name, what, expected, actual);
			abort_run();
		end
	endtask

	task automatic fill_frame(input pattern_e pattern, input int height);
		int r;
		int c;
		for (r = 0; r < height; r++)
			for (c = 0; c < LINE_PIXELS; c++)
			begin
				case (pattern)
					PAT_CONST: frame[r][c] = pixel_t'(677);
					PAT_HRAMP: frame[r][c] = pixel_t'(c * 61 + 5);
					PAT_VRAMP: frame[r][c] = pixel_t'(r * 83 + 7);
					default:
					begin
						rng_state   = xorshift32(rng_state);
						frame[r][c] = rng_state[PIXEL_WIDTH-1:0];
					end
				endcase
			end
	endtask

	// rows 0 to height-2 in raster order
	task automatic build_expected(input int height);
		int r;
		int c;
		int ctr, up, dn, lf, rt;
		pixel_t orth, diag, hz, vt;
		rgb_t px;
		expected_q.delete();
		for (r = 0; r < height - 1; r++)
			for (c = 0; c < LINE_PIXELS; c++)
			begin
				ctr  = sample(r, c);
				up   = sample(r - 1, c);
				dn   = sample(r + 1, c);
				lf   = sample(r, c - 1);
				rt   = sample(r, c + 1);
				orth = mean4(up, dn, lf, rt);
				diag = mean4(sample(r - 1, c - 1), sample(r - 1, c + 1),
					sample(r + 1, c - 1), sample(r + 1, c + 1));
				hz   = mean4(lf, lf, rt, rt);
				vt   = mean4(up, up, dn, dn);
				case ({r[0], c[0]})
					2'b00: px = '{red: pixel_t'(ctr), green: orth, blue: diag};
					2'b01: px = '{red: hz, green: pixel_t'(ctr), blue: vt};	// green in red row
					2'b10: px = '{red: vt, green: pixel_t'(ctr), blue: hz};
					default: px = '{red: diag, green: orth, blue: pixel_t'(ctr)};
				endcase
				expected_q.push_back(px);
			end
	endtask

	task automatic pulse_line_valid(input int cycles);
		int i;
		@(posedge clk_i);
		line_valid_i <= 1'b1;
		pix_valid_i  <= 1'b0;
		rgb_ready_i  <= 1'b1;
		for (i = 0; i < cycles; i++)
			@(posedge clk_i);
		line_valid_i <= 1'b0;
		@(posedge clk_i);
		check_value("rgb_valid_o after pulse", 32'd0, 32'(rgb_valid_o));
		check_value("pix_ready_o after pulse", 32'd1, 32'(pix_ready_o));
	endtask

	task automatic run_frame(input test_entry_t t);
		int total;
		int limit;
		int sent;
		int received;
		int waited;
		int i;
		rgb_t exp_rgb;
		total    = int'(t.height) * LINE_PIXELS;
		limit    = (t.abort_at != 0) ? int'(t.abort_at) : total;
		sent     = 0;
		received = 0;
		waited   = 0;
		while (sent < limit || (t.abort_at == 0 && expected_q.size() != 0))
		begin
			@(posedge clk_i);
			if (rgb_valid_o && rgb_ready_i)
			begin
				if (expected_q.size() == 0)
				begin
					$display("output beyond the expected %0d pixels in %s", received, test_name);
					abort_run();
				end
				exp_rgb = expected_q.pop_front();
				check_value($sformatf("pixel %0d", received), 32'(exp_rgb), 32'(rgb_o));
				received++;
			end
			if (pix_valid_i && pix_ready_o)
				sent++;
			pix_valid_i <= (sent < limit);
			if (sent < limit)
				pix_i <= frame[sent / LINE_PIXELS][sent % LINE_PIXELS];
			if (t.stall)
			begin
				rng_state = xorshift32(rng_state);
				rgb_ready_i <= rng_state[7];
			end
			else
				rgb_ready_i <= 1'b1;
			waited++;
			if (waited > TIMEOUT)
			begin
				$display("timeout: frame %s did not finish in %0d cycles", test_name, TIMEOUT);
				abort_run();
			end
		end
		if (t.abort_at != 0)
		begin
			pulse_line_valid(2);	// drops the half-finished frame
			expected_q.delete();
		end
		else
		begin
			rgb_ready_i <= 1'b1;
			for (i = 0; i < 3 * LINE_PIXELS; i++)
			begin
				@(posedge clk_i);
				check_value("rgb_valid_o after last row", 32'd0, 32'(rgb_valid_o));
			end
		end
	endtask

	always @(posedge clk_i)
	begin
		if (i_dut.i_checker.assert_fails != 0)
		begin
			$display("a handshake assertion failed during %s", test_name);
			abort_run();
		end
	end

	initial
	begin
		clk_i        = 1'b0;
		line_valid_i = 1'b1;
		pix_i        = '0;
		pix_valid_i  = 1'b0;
		rgb_ready_i  = 1'b1;
		rng_state    = 32'd43;
		test_name    = "reset";
		pulse_line_valid(10);
		for (n = 0; n < NUM_TESTS; n++)
		begin
			test_name = $sformatf("%s", TESTS[n].name);
			fill_frame(TESTS[n].pattern, int'(TESTS[n].height));
			build_expected(int'(TESTS[n].height));
			pulse_line_valid(2);	// every frame starts with a pulse
			run_frame(TESTS[n]);
		end
		if (i_dut.i_checker.assert_fails == 0)
		begin
			$display("=== PASS ===");
			$finish;
		end
		else
		begin
			abort_run();
		end
	end

endmodule

// ==== sources.f ====
design/debayer_pkg.sv
design/line_buffer_ram.sv
design/line_store.sv
design/window_3x3.sv
design/bayer_interp.sv
design/debayer_top.sv
tb/debayer_checker.sv
tb/debayer_tb.sv

// ==== Makefile ====
SIM = obj_dir/Vdebayer_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module debayer_tb -f sources.f

run: compile
	$(SIM) +verilator+error+limit+100 | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log
